// ==== cnn_unit.f ====
+incdir+verilog
verilog/cnn_data_pkg.sv
verilog/cnn_flow_pkg.sv
verilog/cnn_stream_if.sv
verilog/window_intake.sv
verilog/weight_store.sv
verilog/conv_mac.sv
verilog/accum_relu.sv
verilog/cnn_unit.sv
tests/cnn_unit_assertions.sv
tests/cnn_unit_tb.sv

// ==== run_sim.sh ====
#!/bin/sh
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -Wno-fatal --top-module cnn_unit_tb \
	-f cnn_unit.f -o cnn_unit_sim

status=0
./obj_dir/cnn_unit_sim > sim.log 2>&1 || status=$?
cat sim.log

if grep -q "TEST FAIL" sim.log || [ "$status" -ne 0 ]; then
	echo "Simulation failed"
	exit 1
fi
echo "Simulation passed"

// ==== tests/cnn_unit_assertions.sv ====
`timescale 1ns/1ps
`include "cnn_unit_consts.svh"

module cnn_unit_assertions (
	input logic clk,
	input logic rst_n,
	input logic win_valid,
	input logic in_credit,
	input logic out_valid,
	input logic out_credit
);

	int fifo_fill; // Windows held by the intake FIFO.
	int sink_credits; // Credits granted by the sink.

	always_ff @(posedge clk) begin
		if (!rst_n) begin
			fifo_fill <= 0;
			sink_credits <= `CNN_OUT_CREDITS;
		end else begin
			fifo_fill <= fifo_fill + int'(win_valid) - int'(in_credit);
			sink_credits <= sink_credits - int'(out_valid) + int'(out_credit);
		end
	end

	// Outputs quiet one edge after any reset edge.
	reset_quiet: assert property (@(posedge clk) !rst_n |=> !in_credit && !out_valid)
		else $error("in_credit or out_valid high while in reset");

	// A pop in the same cycle does not make room.
	no_push_when_full: assert property (@(posedge clk) disable iff (!rst_n)
		win_valid |-> fifo_fill < `CNN_IN_FIFO_DEPTH)
		else $error("window pushed into a full intake FIFO");

	out_within_credit: assert property (@(posedge clk) disable iff (!rst_n)
		out_valid |-> sink_credits > 0)
		else $error("result sent without a returned output credit");

endmodule

bind cnn_unit cnn_unit_assertions u_assertions (
	.clk (clk),
	.rst_n (rst_n),
	.win_valid (win_valid),
	.in_credit (in_credit),
	.out_valid (out_valid),
	.out_credit (out_credit)
);

// ==== tests/cnn_unit_tb.sv ====
`timescale 1ns/1ps
`include "cnn_unit_consts.svh"

module cnn_unit_tb;
	import cnn_data_pkg::*;
	import cnn_flow_pkg::*;

	localparam int WINDOWS = 98; // 6 + 36 + 52 + 4.
	localparam int TIMEOUT_CYCLES = WINDOWS * 40 + 1000;

	logic clk;
	logic rst_n;
	logic relu_en;
	logic wt_we;
	wt_addr_t wt_addr;
	weight_t wt_data;
	logic win_valid;
	pixel_win_t win_pixels;
	chan_t win_chan;
	sum_t win_bias;
	logic win_last;
	logic in_credit;
	logic out_valid;
	sum_t out_data;
	logic out_credit;

	logic [31:0] lfsr_state = 32'h9a81_cbca;
	weight_t ref_w [`CNN_IFM_DEPTH][`CNN_KERNEL_TAPS]; // Host copy of the kernels.
	sum_t exp_q [$];
	int cyc = 0;
	int snd_credits = `CNN_IN_FIFO_DEPTH;
	int min_credits = `CNN_IN_FIFO_DEPTH; // Lowest count the sender reached.
	int credit_pend = 0;
	int credit_pulses = 0;
	int windows_sent = 0;
	int held = 0; // Results not yet freed by the sink.
	int gap = 0;
	int results_seen = 0;
	int hold_cycles = 0; // Timed sink stall.
	logic sink_hold = 1'b0;

	cnn_unit UUT (.*);

	initial begin
		clk = 1'b0;
		forever #10 clk = ~clk;
	end

	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	// Checks and random source
	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

	task automatic report_failure();
		$display("TEST FAIL");
		$fatal(1, "stopping at first error");
	endtask

	task automatic check_result(input string name, input sum_t got, input sum_t exp);
		if (got !== exp) begin
			$display("MISMATCH %s: got %h, expected %h", name, got, exp);
			report_failure();
		end
	endtask

	task automatic check_credit_count(input string name, input int got, input int exp);
		if (got != exp) begin
			$display("MISMATCH %s: got %h, expected %h", name, got, exp);
			report_failure();
		end
	endtask

	// Fibonacci LFSR with taps 32 22 2 1.
	function automatic logic [31:0] rand_bits(input int n);
		logic [31:0] r;
		logic fb;
		r = '0;
		for (int i = 0; i < n; i++) begin
			fb = lfsr_state[31] ^ lfsr_state[21] ^ lfsr_state[1] ^ lfsr_state[0];
			lfsr_state = {lfsr_state[30:0], fb};
			r = {r[30:0], fb};
		end
		return r;
	endfunction

	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	// Cycle step, sender and sink
	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

	task automatic step();
		@(negedge clk);
		cyc++;
		if (cyc > TIMEOUT_CYCLES) begin
			$display("Timeout after %0d cycles with results still missing", cyc);
			report_failure();
		end
		win_valid = 1'b0;
		wt_we = 1'b0;
		out_credit = 1'b0;
		if (rst_n) begin
			snd_credits += credit_pend; // Usable once the pop edge has passed.
			credit_pend = in_credit ? 1 : 0;
			credit_pulses += credit_pend;
			if (windows_sent == 0 && (in_credit || out_valid)) begin
				$display("Output activity seen before any window was sent");
				report_failure();
			end
			if (snd_credits > `CNN_IN_FIFO_DEPTH) begin
				$display("Sender got back more credits than it spent");
				report_failure();
			end
			if (out_valid) begin
				if (exp_q.size() == 0) begin
					$display("Result arrived when none was expected");
					report_failure();
				end
				check_result("out_data", out_data, exp_q.pop_front());
				results_seen++;
				held++;
				if (held > `CNN_OUT_CREDITS) begin
					$display("Sink received more results than it had credits for");
					report_failure();
				end
			end
			if (!sink_hold && hold_cycles == 0 && held > 0) begin
				if (gap == 0) begin
					out_credit = 1'b1;
					held--;
					gap = int'(rand_bits(3));
				end else
					gap--;
			end
			if (hold_cycles > 0)
				hold_cycles--;
		end
	endtask

	task automatic send_window(input chan_t c, input pixel_win_t p, input sum_t b, input logic last);
		step();
		while (snd_credits == 0)
			step();
		win_valid = 1'b1;
		win_pixels = p;
		win_chan = c;
		win_bias = b;
		win_last = last;
		snd_credits--;
		windows_sent++;
		if (snd_credits < min_credits)
			min_credits = snd_credits;
	endtask

	// One output over nchan channels and its expected value.
	task automatic send_output(input int nchan, input bit zero_pix = 1'b0);
		pixel_win_t p;
		sum_t b;
		sum_t acc;
		sum_t dot;
		acc = '0;
		for (int c = 0; c < nchan; c++) begin
			if (zero_pix)
				b = -1 - sum_t'(rand_bits(15)); // Always negative.
			else
				b = sum_t'(rand_bits(16)) - 32768;
			dot = '0;
			for (int t = 0; t < `CNN_KERNEL_TAPS; t++) begin
				p[t] = zero_pix ? pixel_t'(0) : pixel_t'(rand_bits(8));
				dot += int'(p[t]) * int'(ref_w[c][t]);
			end
			acc = (c == 0) ? dot + b : acc + dot;
			send_window(chan_t'(c), p, b, c == nchan - 1);
		end
		exp_q.push_back((relu_en && acc < 0) ? sum_t'(0) : acc);
	endtask

	task automatic drain();
		while (exp_q.size() != 0 || held != 0)
			step();
		repeat (4) step();
	endtask

	initial begin
		int base;
		rst_n = 1'b0;
		relu_en = 1'b0;
		wt_we = 1'b0;
		wt_addr = '0;
		wt_data = '0;
		win_valid = 1'b0;
		win_pixels = '0;
		win_chan = '0;
		win_bias = '0;
		win_last = 1'b0;
		out_credit = 1'b0;
		repeat (4) step();
		rst_n = 1'b1;
		repeat (10) step();

		for (int a = 0; a < `CNN_IFM_DEPTH * `CNN_KERNEL_TAPS; a++) begin
			step();
			wt_we = 1'b1;
			wt_addr = wt_addr_t'(a);
			wt_data = weight_t'(rand_bits(8));
			ref_w[a / `CNN_KERNEL_TAPS][a % `CNN_KERNEL_TAPS] = wt_data;
		end
		repeat (6) send_output(1); // Channel 0 only.
		drain();

		// Sink stalls long enough for the sender to run dry.
		hold_cycles = 60;
		repeat (6) send_output(`CNN_IFM_DEPTH);
		drain();
		check_credit_count("lowest sender credits", min_credits, 0);
		check_credit_count("in_credit pulses", credit_pulses, windows_sent);
		check_credit_count("sender credits", snd_credits + credit_pend, `CNN_IN_FIFO_DEPTH);

		for (int ph = 0; ph < 4; ph++) begin
			if (ph < 2)
				relu_en = (ph == 0);
			else
				relu_en = rand_bits(1) != 0;
			repeat (2) send_output(`CNN_IFM_DEPTH);
			send_output(1, 1'b1); // Zero pixels, negative bias.
			drain();
		end

		// Sink keeps its credits.
		sink_hold = 1'b1;
		base = results_seen;
		repeat (4) send_output(1);
		repeat (60) step();
		check_credit_count("results while credits withheld", results_seen - base,
			`CNN_OUT_CREDITS);
		sink_hold = 1'b0;
		drain();
		check_credit_count("in_credit pulses", credit_pulses, windows_sent);

		$display("TEST PASS");
		$finish;
	end

endmodule

// ==== verilog/accum_relu.sv ====
`timescale 1ns/1ps
`include "cnn_unit_consts.svh"

module accum_relu (
	input logic clk,
	input logic rst_n,
	input logic relu_en,
	input logic out_credit,
	mac_if.sink mac,
	output logic out_valid,
	output cnn_data_pkg::sum_t out_data
);
	import cnn_data_pkg::*;

	sum_t acc;
	sum_t acc_next;
	sum_t res_data;
	logic res_full;
	logic send;
	logic take;
	logic [`CNN_OUT_CREDIT_W-1:0] credits;

	assign send = res_full && (credits != '0);
	// Stall only with a stuck result.
	assign mac.ready = !res_full || send;
	assign take = mac.valid && mac.ready;

	assign acc_next = mac.first ? mac.dot + mac.bias : acc + mac.dot;

	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	// Result and credits
	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

	always_ff @(posedge clk) begin
		if (!rst_n) begin
			res_full <= 1'b0;
			credits <= (`CNN_OUT_CREDIT_W)'(`CNN_OUT_CREDITS);
		end else begin
			if (take && mac.last)
				res_full <= 1'b1; // Refill wins over send.
			else if (send)
				res_full <= 1'b0;
			case ({send, out_credit})
				2'b10: credits <= credits - (`CNN_OUT_CREDIT_W)'(1);
				2'b01: credits <= credits + (`CNN_OUT_CREDIT_W)'(1);
				default: ;
			endcase
		end
	end

	// Running sum over channels.
	always_ff @(posedge clk) begin
		if (take) begin
			acc <= acc_next;
			if (mac.last) begin
				if (relu_en && acc_next[`CNN_SUM_W-1])
					res_data <= '0;
				else
					res_data <= acc_next;
			end
		end
	end

	assign out_valid = send;
	assign out_data = res_data;

endmodule

// ==== verilog/cnn_data_pkg.sv ====
`include "cnn_unit_consts.svh"

package cnn_data_pkg;

	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	// Scalars
	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

	typedef logic [`CNN_PIXEL_W-1:0] pixel_t; // Unsigned.

	typedef logic signed [`CNN_WEIGHT_W-1:0] weight_t;

	// One extra bit for the unsigned pixel operand.
	typedef logic signed [`CNN_PIXEL_W+`CNN_WEIGHT_W:0] product_t;

	typedef logic signed [`CNN_SUM_W-1:0] sum_t; // Also bias and result.

	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	// Window arrays
	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

	typedef pixel_t [`CNN_KERNEL_TAPS-1:0] pixel_win_t;

	typedef weight_t [`CNN_KERNEL_TAPS-1:0] kernel_t;

endpackage

// ==== verilog/cnn_flow_pkg.sv ====
`include "cnn_unit_consts.svh"

package cnn_flow_pkg;

	// Input channel number.
	typedef logic [$clog2(`CNN_IFM_DEPTH)-1:0] chan_t;

	// Flat weight address, channel * taps + tap.
	typedef logic [$clog2(`CNN_KERNEL_TAPS * `CNN_IFM_DEPTH)-1:0] wt_addr_t;

endpackage

// ==== verilog/cnn_stream_if.sv ====
`timescale 1ns/1ps

// Intake FIFO to MAC pipeline.
interface window_if;
	import cnn_data_pkg::*;
	import cnn_flow_pkg::*;

	logic valid;
	pixel_win_t pixels;
	chan_t chan;
	sum_t bias;
	logic last;
	logic ready;

	modport source (output valid, pixels, chan, bias, last, input ready);
	modport sink (input valid, pixels, chan, bias, last, output ready);
	// Weight store only needs the channel of each transfer.
	modport monitor (input valid, chan, ready);

endinterface

// MAC pipeline to accumulator.
interface mac_if;
	import cnn_data_pkg::*;

	logic valid;
	sum_t dot;
	sum_t bias;
	logic first;
	logic last;
	logic ready;

	modport source (output valid, dot, bias, first, last, input ready);
	modport sink (input valid, dot, bias, first, last, output ready);

endinterface

// ==== verilog/cnn_unit.sv ====
`timescale 1ns/1ps

module cnn_unit (
	input logic clk,
	input logic rst_n,
	input logic relu_en,

	// Host weight port.
	input logic wt_we,
	input cnn_flow_pkg::wt_addr_t wt_addr,
	input cnn_data_pkg::weight_t wt_data,

	// Window port.
	input logic win_valid,
	input cnn_data_pkg::pixel_win_t win_pixels,
	input cnn_flow_pkg::chan_t win_chan,
	input cnn_data_pkg::sum_t win_bias,
	input logic win_last,
	output logic in_credit,

	// Result port.
	output logic out_valid,
	output cnn_data_pkg::sum_t out_data,
	input logic out_credit
);
	import cnn_data_pkg::*;

	window_if win_bus ();
	mac_if mac_bus ();

	kernel_t kernel; // Row for the window in capture.

	window_intake u_intake (
		.clk (clk),
		.rst_n (rst_n),
		.win_valid (win_valid),
		.win_pixels (win_pixels),
		.win_chan (win_chan),
		.win_bias (win_bias),
		.win_last (win_last),
		.in_credit (in_credit),
		.win (win_bus.source)
	);

	weight_store u_weights (
		.clk (clk),
		.wt_we (wt_we),
		.wt_addr (wt_addr),
		.wt_data (wt_data),
		.win (win_bus.monitor),
		.kernel (kernel)
	);

	conv_mac u_mac (
		.clk (clk),
		.rst_n (rst_n),
		.win (win_bus.sink),
		.kernel (kernel),
		.mac (mac_bus.source)
	);

	accum_relu u_accum (
		.clk (clk),
		.rst_n (rst_n),
		.relu_en (relu_en),
		.out_credit (out_credit),
		.mac (mac_bus.sink),
		.out_valid (out_valid),
		.out_data (out_data)
	);

endmodule

// ==== verilog/cnn_unit_consts.svh ====
`ifndef CNN_UNIT_CONSTS_SVH
`define CNN_UNIT_CONSTS_SVH

// Kernel geometry.
`define CNN_KERNEL_DIM    5
`define CNN_KERNEL_TAPS   (`CNN_KERNEL_DIM * `CNN_KERNEL_DIM)
`define CNN_IFM_DEPTH     6

// Datapath widths.
`define CNN_PIXEL_W       8
`define CNN_WEIGHT_W      8
`define CNN_SUM_W         32

// Flow control.
`define CNN_IN_FIFO_DEPTH 4
`define CNN_OUT_CREDITS   2

`define CNN_FIFO_PTR_W    ($clog2(`CNN_IN_FIFO_DEPTH))
`define CNN_FIFO_CNT_W    ($clog2(`CNN_IN_FIFO_DEPTH + 1))
`define CNN_OUT_CREDIT_W  ($clog2(`CNN_OUT_CREDITS + 1))
`define CNN_TAP_W         ($clog2(`CNN_KERNEL_TAPS))

`endif

// ==== verilog/conv_mac.sv ====
`timescale 1ns/1ps
`include "cnn_unit_consts.svh"

module conv_mac (
	input logic clk,
	input logic rst_n,
	window_if.sink win,
	input cnn_data_pkg::kernel_t kernel,
	mac_if.source mac
);
	import cnn_data_pkg::*;

	logic advance;

	// Window capture, aligned with the kernel read.
	logic s0_valid;
	logic s0_first;
	logic s0_last;
	pixel_win_t s0_pix;
	sum_t s0_bias;

	// Products.
	logic s1_valid;
	logic s1_first;
	logic s1_last;
	product_t s1_prod [`CNN_KERNEL_TAPS];
	sum_t s1_bias;

	// Partial sums.
	logic s2_valid;
	logic s2_first;
	logic s2_last;
	sum_t s2_part [`CNN_KERNEL_DIM];
	sum_t s2_bias;

	sum_t part_next [`CNN_KERNEL_DIM];
	sum_t dot_next;

	// Whole pipeline holds on back-pressure.
	assign advance = mac.ready;
	assign win.ready = advance;

	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	// Adder tree
	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

	always_comb begin
		for (int g = 0; g < `CNN_KERNEL_DIM; g++) begin
			part_next[g] = '0;
			for (int k = 0; k < `CNN_KERNEL_DIM; k++)
				part_next[g] = part_next[g] + sum_t'(s1_prod[g * `CNN_KERNEL_DIM + k]);
		end
	end

	always_comb begin
		dot_next = '0;
		for (int g = 0; g < `CNN_KERNEL_DIM; g++)
			dot_next = dot_next + s2_part[g];
	end

	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	// Stage valids
	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

	always_ff @(posedge clk) begin
		if (!rst_n) begin
			s0_valid <= 1'b0;
			s1_valid <= 1'b0;
			s2_valid <= 1'b0;
			mac.valid <= 1'b0;
		end else if (advance) begin
			s0_valid <= win.valid;
			s1_valid <= s0_valid;
			s2_valid <= s1_valid;
			mac.valid <= s2_valid;
		end
	end

	// Payload, with flags riding alongside.
	always_ff @(posedge clk) begin
		if (advance) begin
			s0_pix <= win.pixels;
			s0_bias <= win.bias;
			s0_first <= (win.chan == '0); // Bias enters on channel 0.
			s0_last <= win.last;

			for (int t = 0; t < `CNN_KERNEL_TAPS; t++)
				s1_prod[t] <= $signed({1'b0, s0_pix[t]}) * $signed(kernel[t]);
			s1_bias <= s0_bias;
			s1_first <= s0_first;
			s1_last <= s0_last;

			for (int g = 0; g < `CNN_KERNEL_DIM; g++)
				s2_part[g] <= part_next[g];
			s2_bias <= s1_bias;
			s2_first <= s1_first;
			s2_last <= s1_last;

			mac.dot <= dot_next;
			mac.bias <= s2_bias;
			mac.first <= s2_first;
			mac.last <= s2_last;
		end
	end

endmodule

// ==== verilog/weight_store.sv ====
`timescale 1ns/1ps
`include "cnn_unit_consts.svh"

module weight_store (
	input logic clk,
	input logic wt_we,
	input cnn_flow_pkg::wt_addr_t wt_addr,
	input cnn_data_pkg::weight_t wt_data,
	window_if.monitor win,
	output cnn_data_pkg::kernel_t kernel
);
	import cnn_data_pkg::*;
	import cnn_flow_pkg::*;

	kernel_t rows [`CNN_IFM_DEPTH]; // One kernel per input channel.

	chan_t wr_row;
	logic [`CNN_TAP_W-1:0] wr_tap;
	logic wr_ok;
	logic rd_en;

	// Flat host address to row and tap.
	assign wr_row = chan_t'(wt_addr / `CNN_KERNEL_TAPS);
	assign wr_tap = (`CNN_TAP_W)'(wt_addr % `CNN_KERNEL_TAPS);
	assign wr_ok = wt_we && (wt_addr < wt_addr_t'(`CNN_KERNEL_TAPS * `CNN_IFM_DEPTH));

	assign rd_en = win.valid && win.ready;

	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	// Host writes
	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

	always_ff @(posedge clk) begin
		if (wr_ok)
			rows[wr_row][wr_tap] <= wt_data;
	end

	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	// Kernel read
	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

	// Lands in step with the window capture in conv_mac.
	always_ff @(posedge clk) begin
		if (rd_en)
			kernel <= rows[win.chan];
	end

endmodule

// ==== verilog/window_intake.sv ====
`timescale 1ns/1ps
`include "cnn_unit_consts.svh"

module window_intake (
	input logic clk,
	input logic rst_n,
	input logic win_valid,
	input cnn_data_pkg::pixel_win_t win_pixels,
	input cnn_flow_pkg::chan_t win_chan,
	input cnn_data_pkg::sum_t win_bias,
	input logic win_last,
	output logic in_credit,
	window_if.source win
);
	import cnn_data_pkg::*;
	import cnn_flow_pkg::*;

	pixel_win_t pix_mem [`CNN_IN_FIFO_DEPTH];
	chan_t chan_mem [`CNN_IN_FIFO_DEPTH];
	sum_t bias_mem [`CNN_IN_FIFO_DEPTH];
	logic [`CNN_IN_FIFO_DEPTH-1:0] last_mem;

	logic [`CNN_FIFO_PTR_W-1:0] wr_ptr;
	logic [`CNN_FIFO_PTR_W-1:0] rd_ptr;
	logic [`CNN_FIFO_CNT_W-1:0] count;
	logic full;
	logic push;
	logic pop;

	function automatic logic [`CNN_FIFO_PTR_W-1:0] next_ptr(
		input logic [`CNN_FIFO_PTR_W-1:0] ptr
	);
		if (ptr == (`CNN_FIFO_PTR_W)'(`CNN_IN_FIFO_DEPTH - 1))
			return '0;
		return ptr + (`CNN_FIFO_PTR_W)'(1);
	endfunction

	assign full = (count == (`CNN_FIFO_CNT_W)'(`CNN_IN_FIFO_DEPTH));
	assign push = win_valid && !full; // Sender holds a credit.
	assign pop = win.valid && win.ready;

	assign in_credit = pop; // One credit back per freed entry.

	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	// Pointers and occupancy
	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

	always_ff @(posedge clk) begin
		if (!rst_n) begin
			wr_ptr <= '0;
			rd_ptr <= '0;
			count <= '0;
		end else begin
			if (push)
				wr_ptr <= next_ptr(wr_ptr);
			if (pop)
				rd_ptr <= next_ptr(rd_ptr);
			case ({push, pop})
				2'b10: count <= count + (`CNN_FIFO_CNT_W)'(1);
				2'b01: count <= count - (`CNN_FIFO_CNT_W)'(1);
				default: ;
			endcase
		end
	end

	// Storage.
	always_ff @(posedge clk) begin
		if (push) begin
			pix_mem[wr_ptr] <= win_pixels;
			chan_mem[wr_ptr] <= win_chan;
			bias_mem[wr_ptr] <= win_bias;
			last_mem[wr_ptr] <= win_last;
		end
	end

	assign win.valid = (count != '0);
	assign win.pixels = pix_mem[rd_ptr];
	assign win.chan = chan_mem[rd_ptr];
	assign win.bias = bias_mem[rd_ptr];
	assign win.last = last_mem[rd_ptr];

endmodule
